// ==== src/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and register file
`define XLEN        32
`define REG_ADDR_W  5

// External ROM word address width
`define ROM_ADDR_W  8

`define RAM_WORDS   64  // Data RAM depth in words

`define LED_REG     1   // Register shown on the LEDs
`define LED_W       6

`endif

// ==== src/isa_pkg.sv ====
`include "cpu_cfg.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]             opcode_t;

    // Major opcodes of the supported subset
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // funct3 / funct7 values
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;  // lw and sw
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

endpackage

// ==== src/pipe_pkg.sv ====
`include "cpu_cfg.svh"

package pipe_pkg;

    // Byte address carried along with each instruction
    typedef logic [`XLEN-1:0] pc_t;

    // Word index into the external ROM
    typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;

    // Word index into the data RAM
    typedef logic [$clog2(`RAM_WORDS)-1:0] ram_index_t;

    typedef logic [`LED_W-1:0] led_t;

endpackage

// ==== src/stage_if.sv ====
// Decode to execute bundle
interface de_ex_if;
    logic                valid;
    pipe_pkg::pc_t       pc;
    isa_pkg::word_t      rs1_value;
    isa_pkg::word_t      rs2_value;
    isa_pkg::word_t      imm;
    isa_pkg::reg_addr_t  rd;
    isa_pkg::alu_op_t    alu_op;
    logic                alu_src_imm;   // Second ALU operand is imm
    logic                is_branch;
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;

    modport producer (output valid, pc, rs1_value, rs2_value, imm, rd, alu_op,
                      alu_src_imm, is_branch, mem_read, mem_write, reg_write);
    modport consumer (input valid, pc, rs1_value, rs2_value, imm, rd, alu_op,
                      alu_src_imm, is_branch, mem_read, mem_write, reg_write);
endinterface

// Execute to memory bundle
interface ex_mem_if;
    logic                valid;
    isa_pkg::word_t      result;       // ALU result or memory address
    isa_pkg::word_t      store_data;
    isa_pkg::reg_addr_t  rd;
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;

    modport producer (output valid, result, store_data, rd, mem_read, mem_write, reg_write);
    modport consumer (input valid, result, store_data, rd, mem_read, mem_write, reg_write);
endinterface

// ==== src/register_bank.sv ====
`include "cpu_cfg.svh"

module register_bank (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable,
    input  isa_pkg::reg_addr_t  rs1,
    input  isa_pkg::reg_addr_t  rs2,
    output isa_pkg::word_t      value1,
    output isa_pkg::word_t      value2,
    input  logic                wb_enable,
    input  isa_pkg::reg_addr_t  wb_rd,
    input  isa_pkg::word_t      wb_value,
    output pipe_pkg::led_t      led
);

    isa_pkg::word_t regs [2**`REG_ADDR_W];

    // Write-through read, x0 never bypassed
    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_addr_t addr);
        isa_pkg::word_t value;
        value = regs[addr];
        if (wb_enable && addr == wb_rd && addr != '0)
            value = wb_value;
        return value;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++)
                regs[i] <= '0;
        end else if (enable && wb_enable && wb_rd != '0) begin
            regs[wb_rd] <= wb_value;
        end
    end

    always_comb value1 = read_port(rs1);
    always_comb value2 = read_port(rs2);

    assign led = regs[`LED_REG][`LED_W-1:0];  // Registered value only

endmodule

// ==== src/fetch.sv ====
module fetch (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,
    input  logic                 redirect,
    input  pipe_pkg::pc_t        redirect_target,
    output pipe_pkg::rom_addr_t  rom_address,
    input  isa_pkg::word_t       rom_data,
    output isa_pkg::word_t       instr,
    output pipe_pkg::pc_t        instr_pc,
    output logic                 instr_valid
);

    pipe_pkg::pc_t pc;

    assign rom_address = pc[2 +: $bits(pipe_pkg::rom_addr_t)];  // Word index

    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else if (enable) begin
            pc          <= redirect ? redirect_target : pc + 32'd4;
            instr_valid <= !redirect;  // Wrong-path fetch
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            instr    <= rom_data;
            instr_pc <= pc;
        end
    end

endmodule

// ==== src/decode.sv ====
module decode (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable,
    input  isa_pkg::word_t      instr,
    input  pipe_pkg::pc_t       instr_pc,
    input  logic                instr_valid,
    input  logic                redirect,
    output isa_pkg::reg_addr_t  rs1,
    output isa_pkg::reg_addr_t  rs2,
    input  isa_pkg::word_t      value1,
    input  isa_pkg::word_t      value2,
    de_ex_if.producer           de
);

    isa_pkg::opcode_t    opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    isa_pkg::reg_addr_t  rd;
    isa_pkg::word_t      imm_i;
    isa_pkg::word_t      imm_s;
    isa_pkg::word_t      imm_b;
    isa_pkg::word_t      imm;
    isa_pkg::alu_op_t    funct_op;
    isa_pkg::alu_op_t    alu_op;
    logic                funct_known;
    logic                known;
    logic                alu_src_imm;
    logic                is_branch;
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // funct3 to ALU operation, shared by register and immediate forms
    always_comb begin
        funct_known = 1'b1;
        case (funct3)
            isa_pkg::F3_ADD: begin
                if (opcode == isa_pkg::OP_REG && funct7 == isa_pkg::F7_SUB)
                    funct_op = isa_pkg::ALU_SUB;
                else
                    funct_op = isa_pkg::ALU_ADD;
            end
            isa_pkg::F3_XOR: funct_op = isa_pkg::ALU_XOR;
            isa_pkg::F3_OR:  funct_op = isa_pkg::ALU_OR;
            isa_pkg::F3_AND: funct_op = isa_pkg::ALU_AND;
            default: begin
                funct_op    = isa_pkg::ALU_ADD;
                funct_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        known       = 1'b0;
        imm         = imm_i;
        alu_op      = isa_pkg::ALU_ADD;  // Address adder for loads and stores
        alu_src_imm = 1'b0;
        is_branch   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        case (opcode)
            isa_pkg::OP_REG: begin
                known     = funct_known;
                alu_op    = funct_op;
                reg_write = 1'b1;
            end
            isa_pkg::OP_IMM: begin
                known       = funct_known;
                alu_op      = funct_op;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            isa_pkg::OP_LOAD: begin
                known       = (funct3 == isa_pkg::F3_WORD);
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
            end
            isa_pkg::OP_STORE: begin
                known       = (funct3 == isa_pkg::F3_WORD);
                imm         = imm_s;
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            isa_pkg::OP_BRANCH: begin
                known     = (funct3 == isa_pkg::F3_BEQ);
                imm       = imm_b;
                alu_op    = isa_pkg::ALU_SUB;
                is_branch = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            de.valid     <= 1'b0;
            de.is_branch <= 1'b0;
            de.mem_read  <= 1'b0;
            de.mem_write <= 1'b0;
            de.reg_write <= 1'b0;
        end else if (enable) begin
            de.valid     <= instr_valid && known && !redirect;  // Squash on taken beq
            de.is_branch <= is_branch;
            de.mem_read  <= mem_read;
            de.mem_write <= mem_write;
            de.reg_write <= reg_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            de.pc          <= instr_pc;
            de.rs1_value   <= value1;
            de.rs2_value   <= value2;
            de.imm         <= imm;
            de.rd          <= rd;
            de.alu_op      <= alu_op;
            de.alu_src_imm <= alu_src_imm;
        end
    end

endmodule

// ==== src/execute.sv ====
module execute (
    input  logic           clock,
    input  logic           reset,
    input  logic           enable,
    de_ex_if.consumer      de,
    ex_mem_if.producer     em,
    output logic           redirect,
    output pipe_pkg::pc_t  redirect_target
);

    isa_pkg::word_t  operand_b;
    isa_pkg::word_t  alu_result;
    pipe_pkg::pc_t   target;
    logic            taken;

    assign operand_b = de.alu_src_imm ? de.imm : de.rs2_value;

    always_comb begin
        case (de.alu_op)
            isa_pkg::ALU_ADD: alu_result = de.rs1_value + operand_b;
            isa_pkg::ALU_SUB: alu_result = de.rs1_value - operand_b;
            isa_pkg::ALU_AND: alu_result = de.rs1_value & operand_b;
            isa_pkg::ALU_OR:  alu_result = de.rs1_value | operand_b;
            isa_pkg::ALU_XOR: alu_result = de.rs1_value ^ operand_b;
            default:          alu_result = de.rs1_value + operand_b;
        endcase
    end

    // beq only; the instruction here during a redirect is on the wrong path
    assign taken  = de.valid && de.is_branch && !redirect
                    && (de.rs1_value == de.rs2_value);
    assign target = de.pc + de.imm;

    always_ff @(posedge clock) begin
        if (reset) begin
            em.valid     <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
            em.reg_write <= 1'b0;
            redirect     <= 1'b0;
        end else if (enable) begin
            em.valid     <= de.valid && !redirect;
            em.mem_read  <= de.mem_read;
            em.mem_write <= de.mem_write;
            em.reg_write <= de.reg_write;
            redirect     <= taken;  // One-cycle pulse
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            em.result       <= alu_result;
            em.store_data   <= de.rs2_value;
            em.rd           <= de.rd;
            redirect_target <= target;
        end
    end

endmodule

// ==== src/memory_stage.sv ====
`include "cpu_cfg.svh"

module memory_stage (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable,
    ex_mem_if.consumer          em,
    output logic                wb_enable,
    output isa_pkg::reg_addr_t  wb_rd,
    output isa_pkg::word_t      wb_value
);

    isa_pkg::word_t        ram [`RAM_WORDS];
    pipe_pkg::ram_index_t  index;
    isa_pkg::word_t        load_word;
    isa_pkg::word_t        wb_next;

    // Word address, upper bits ignored so accesses wrap
    assign index     = em.result[2 +: $bits(pipe_pkg::ram_index_t)];
    assign load_word = ram[index];  // Asynchronous read
    assign wb_next   = em.mem_read ? load_word : em.result;

    always_ff @(posedge clock) begin
        if (enable && em.valid && em.mem_write)
            ram[index] <= em.store_data;
    end

    always_ff @(posedge clock) begin
        if (reset)
            wb_enable <= 1'b0;
        else if (enable)
            wb_enable <= em.valid && em.reg_write;
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            wb_rd    <= em.rd;
            wb_value <= wb_next;
        end
    end

endmodule

// ==== src/cpu.sv ====
module cpu (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,   // Clock enable for the whole core
    input  isa_pkg::word_t       rom_data,
    output pipe_pkg::rom_addr_t  rom_address,
    output pipe_pkg::led_t       led
);

    isa_pkg::reg_addr_t  rs1;
    isa_pkg::reg_addr_t  rs2;
    isa_pkg::word_t      value1;
    isa_pkg::word_t      value2;

    // Write-back into the register bank
    logic                wb_enable;
    isa_pkg::reg_addr_t  wb_rd;
    isa_pkg::word_t      wb_value;

    logic                redirect;
    pipe_pkg::pc_t       redirect_target;

    isa_pkg::word_t      instr;
    pipe_pkg::pc_t       instr_pc;
    logic                instr_valid;

    de_ex_if  de_ex ();
    ex_mem_if ex_mem ();

    register_bank u_register_bank (
        .clock(clock), .reset(reset), .enable(enable),
        .rs1(rs1), .rs2(rs2), .value1(value1), .value2(value2),
        .wb_enable(wb_enable), .wb_rd(wb_rd), .wb_value(wb_value), .led(led)
    );

    fetch u_fetch (
        .clock(clock), .reset(reset), .enable(enable),
        .redirect(redirect), .redirect_target(redirect_target),
        .rom_address(rom_address), .rom_data(rom_data),
        .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid)
    );

    decode u_decode (
        .clock(clock), .reset(reset), .enable(enable),
        .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
        .redirect(redirect), .rs1(rs1), .rs2(rs2),
        .value1(value1), .value2(value2), .de(de_ex.producer)
    );

    execute u_execute (
        .clock(clock), .reset(reset), .enable(enable),
        .de(de_ex.consumer), .em(ex_mem.producer),
        .redirect(redirect), .redirect_target(redirect_target)
    );

    memory_stage u_memory_stage (
        .clock(clock), .reset(reset), .enable(enable), .em(ex_mem.consumer),
        .wb_enable(wb_enable), .wb_rd(wb_rd), .wb_value(wb_value)
    );

endmodule

// ==== verification/cpu_tb.sv ====
module cpu_tb;

    localparam int ROM_WORDS    = 2 ** $bits(pipe_pkg::rom_addr_t);
    localparam int MAX_TESTS    = 16;
    localparam int MAX_WORDS    = 1024;
    localparam int RESET_CYCLES = 16;

    logic                 clock;
    logic                 reset;
    logic                 enable;
    isa_pkg::word_t       rom_data;
    pipe_pkg::rom_addr_t  rom_address;
    pipe_pkg::led_t       led;

    isa_pkg::word_t rom [ROM_WORDS];

    // Tests as read from the stim file
    logic [8*16-1:0]      test_name   [MAX_TESTS];
    int                   test_cycles [MAX_TESTS];
    int                   test_hold   [MAX_TESTS];
    pipe_pkg::led_t       test_expect [MAX_TESTS];
    int                   test_first  [MAX_TESTS];  // First entry in the word lists
    int                   test_words  [MAX_TESTS];
    pipe_pkg::rom_addr_t  word_addr   [MAX_WORDS];
    isa_pkg::word_t       word_data   [MAX_WORDS];

    int n_tests     = 0;
    int n_words     = 0;
    int errors      = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    cpu UUT (
        .clock(clock), .reset(reset), .enable(enable),
        .rom_data(rom_data), .rom_address(rom_address), .led(led)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    assign rom_data = rom[rom_address];  // Combinational ROM

    always @(posedge clock) cycle_count <= cycle_count + 1;

    // addi x0, x0, addr so stray fetches do nothing
    function automatic isa_pkg::word_t fill_word(input pipe_pkg::rom_addr_t addr);
        return {4'b0000, addr, 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    task automatic load_rom(input int t);
        for (int a = 0; a < ROM_WORDS; a++)
            rom[a] <= fill_word(pipe_pkg::rom_addr_t'(a));
        for (int i = 0; i < test_words[t]; i++)
            rom[word_addr[test_first[t] + i]] <= word_data[test_first[t] + i];
    endtask

    task automatic reset_core(input int t);
        @(posedge clock);
        reset  <= 1'b1;
        enable <= 1'b1;
        load_rom(t);
        for (int i = 1; i <= RESET_CYCLES; i++) begin
            @(posedge clock);
            if (i == RESET_CYCLES)
                reset <= 1'b0;
            @(negedge clock);
            if (rom_address !== '0 || led !== '0) begin
                $display("FAIL %0t %0s: in reset rom_address %h led %h, expected 0",
                         $time, test_name[t], rom_address, led);
                errors++;
            end
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    // Freeze the core and watch that fetch stands still
    task automatic hold_core(input int t);
        pipe_pkg::rom_addr_t held;
        @(posedge clock);
        enable <= 1'b0;
        @(negedge clock);
        held = rom_address;
        for (int i = 1; i <= test_hold[t]; i++) begin
            @(posedge clock);
            if (i == test_hold[t])
                enable <= 1'b1;
            @(negedge clock);
            if (rom_address !== held) begin
                $display("FAIL %0t %0s: rom_address moved in hold, expected %h got %h",
                         $time, test_name[t], held, rom_address);
                errors++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int first;
        errors = 0;
        reset_core(t);
        if (test_hold[t] > 0) begin
            first = test_cycles[t] / 2;  // Hold lands mid program
            run_cycles(first - 1);
            hold_core(t);
            run_cycles(test_cycles[t] - first);
        end else begin
            run_cycles(test_cycles[t]);
        end
        @(negedge clock);
        if (led !== test_expect[t]) begin
            $display("FAIL %0t %0s: led expected %h got %h",
                     $time, test_name[t], test_expect[t], led);
            errors++;
        end
        if (errors == 0) begin
            $display("Test %0s: ok, led %h", test_name[t], led);
            pass_count++;
        end else begin
            $display("Test %0s: %0d error(s)", test_name[t], errors);
            fail_count++;
        end
    endtask

    task automatic read_stim(input int fd);
        logic [8*16-1:0]      tag;
        logic [8*16-1:0]      name;
        logic [8*128-1:0]     rest;
        pipe_pkg::rom_addr_t  addr;
        isa_pkg::word_t       word;
        pipe_pkg::led_t       expect_led;
        int                   number;
        int                   code;
        int                   reading;
        reading = 1;
        while (reading) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                reading = 0;
            end else if (tag == "#") begin
                code = $fgets(rest, fd);  // Comment to end of line
            end else if (tag == "T") begin
                code = $fscanf(fd, "%s %d", name, number);
                test_name[n_tests]   = name;
                test_cycles[n_tests] = number;
                test_hold[n_tests]   = 0;
                test_first[n_tests]  = n_words;
                test_words[n_tests]  = 0;
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h %h", addr, word);
                word_addr[n_words] = addr;
                word_data[n_words] = word;
                n_words++;
                test_words[n_tests]++;
            end else if (tag == "H") begin
                code = $fscanf(fd, "%d", number);
                test_hold[n_tests] = number;
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h", expect_led);
                test_expect[n_tests] = expect_led;
                n_tests++;  // E closes a test
            end else begin
                $display("The stim file holds an unknown record %0s", tag);
                fail_count++;
                reading = 0;
            end
        end
    endtask

    initial begin
        int fd;
        reset  = 1'b1;
        enable = 1'b0;
        for (int a = 0; a < ROM_WORDS; a++)
            rom[a] = fill_word(pipe_pkg::rom_addr_t'(a));
        fd = $fopen("verification/cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stim file verification/cpu_stim.txt");
            fail_count++;
        end else begin
            read_stim(fd);
            $fclose(fd);
            if (n_tests == 0) begin
                $display("The stim file holds no tests");
                fail_count++;
            end
            for (int t = 0; t < n_tests; t++)
                cycle_limit += test_cycles[t] + test_hold[t] + RESET_CYCLES + 20;
            for (int t = 0; t < n_tests; t++)
                run_test(t);
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
            @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/stage_if.sv
src/register_bank.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memory_stage.sv
src/cpu.sv
verification/cpu_tb.sv

// ==== verification/cpu_stim.txt ====
# Records: T name cycles | W rom_addr word | H hold_cycles | E expected_led
# Cycles are decimal, everything else hex; E closes a test
T alu_chain 30
W 00 02D00113 # addi x2, x0, 45
W 01 FF200193 # addi x3, x0, -14
W 02 00000013
W 03 00000013
W 04 00310233 # add x4, x2, x3
W 05 403102B3 # sub x5, x2, x3
W 06 00000013
W 07 00000013
W 08 00524333 # xor x6, x4, x5
W 09 005273B3 # and x7, x4, x5
W 0A 00000013
W 0B 00000013
W 0C 007360B3 # or x1, x6, x7
W 0D 00000063 # beq x0, x0, 0
E 3F
T load_store 20
W 00 2A700113 # addi x2, x0, 0x2a7
W 01 00800193 # addi x3, x0, 8
W 02 00000013
W 03 00000013
W 04 0021A223 # sw x2, 4(x3)
W 05 1041A083 # lw x1, 260(x3) wraps to the same word
W 06 00000063
E 27
T branch 24
W 00 00300093 # addi x1, x0, 3
W 01 00000863 # beq x0, x0, +16 taken
W 02 00900093
W 03 00A00093
W 04 00B00093
W 05 00208463 # beq x1, x2, +8 not taken
W 06 02008093 # addi x1, x1, 32
W 07 00000063
E 23
T branch_hold 16
W 00 00300093
W 01 00000863
W 02 00900093
W 03 00A00093
W 04 00B00093
W 05 00208463
W 06 02008093
W 07 00000063
H 7
E 23
T reg_zero 20
W 00 01500013 # addi x0, x0, 21
W 01 00700093 # addi x1, x0, 7
W 02 00000013
W 03 00000013
W 04 000000B3 # add x1, x0, x0
W 05 00000063
E 00
